/* verilog/ssb_defines.svh */
//--------------------
// sparse sample buffer: channel count, sample width, store depths
// and record field widths
//--------------------
`ifndef SSB_DEFINES_SVH
`define SSB_DEFINES_SVH

// input side
`define SSB_CHANNELS 2      // parallel sample channels
`define SSB_SAMPLE_W 16     // bits per sample, signed

// store depths, split evenly into one bank per channel
`define SSB_DATA_DEPTH 64
`define SSB_TS_DEPTH 16

// timestamp record fields, together one 32-bit word
`define SSB_INDEX_W 12      // data-store index of the crossing sample
`define SSB_CLOCK_W 20      // sample-clock value of the crossing sample

// data record fields, channel + reserved + sample = 32 bits
`define SSB_CHAN_W 4
`define SSB_RSVD_W 12

`endif

/* verilog/ssb_pkg.sv */
//--------------------
// sparse sample buffer types: samples, thresholds, records
//--------------------
`default_nettype none

`include "ssb_defines.svh"

package ssb_pkg;

  // one signed sample
  typedef logic signed [`SSB_SAMPLE_W-1:0] sample_t;

  // one sample per channel, all channels side by side
  typedef struct packed {
    sample_t [`SSB_CHANNELS-1:0] ch;
  } sample_vec_t;

  // hysteresis window of one channel
  typedef struct packed {
    sample_t high;  // is_high sets above this
    sample_t low;   // is_high clears below this
  } threshold_t;

  typedef threshold_t [`SSB_CHANNELS-1:0] thresholds_t;

  typedef struct packed {
    logic [`SSB_CHAN_W-1:0]   channel;
    logic [`SSB_RSVD_W-1:0]   reserved;  // always zero
    logic [`SSB_SAMPLE_W-1:0] sample;
  } data_rec_t;

  typedef struct packed {
    logic [`SSB_INDEX_W-1:0] sample_index;  // index into the channel's data bank
    logic [`SSB_CLOCK_W-1:0] clock;         // sample cycles since capture start
  } tstamp_rec_t;

  // output word, read as data or timestamp depending on readout phase
  typedef union packed {
    data_rec_t   data;
    tstamp_rec_t ts;
  } out_word_t;

  // one channel's store write port
  typedef struct packed {
    logic      en;
    out_word_t word;
  } store_wr_t;

endpackage

`default_nettype wire

/* verilog/threshold_discriminator.sv */
//--------------------
// threshold discriminator: per-channel hysteresis, builds data and
// timestamp records one cycle after the sample
//--------------------
`timescale 1ns/1ns
`default_nettype none

`include "ssb_defines.svh"

module threshold_discriminator import ssb_pkg::*; (
  input  wire                                         clk,
  input  wire                                         reset,
  input  wire sample_vec_t                            samples,
  input  wire                                         sample_valid,
  input  wire                                         thr_load,
  input  wire thresholds_t                            thr_cfg,
  input  wire                                         capture_clear,
  input  wire                                         capture_en,
  input  wire [`SSB_CHANNELS-1:0][`SSB_INDEX_W-1:0]   sample_index,
  input  wire [`SSB_CLOCK_W-1:0]                      sample_clock,
  output store_wr_t [`SSB_CHANNELS-1:0]               data_wr,
  output store_wr_t [`SSB_CHANNELS-1:0]               ts_wr,
  output logic [`SSB_CHANNELS-1:0]                    data_inc
);

  localparam int CH = `SSB_CHANNELS;

  thresholds_t         thr_q;        // loaded window per channel
  logic [CH-1:0]       is_high;
  logic [CH-1:0]       next_high;    // is_high after the current sample
  logic [CH-1:0]       data_en_q;
  logic [CH-1:0]       ts_en_q;
  out_word_t [CH-1:0]  data_word_q;
  out_word_t [CH-1:0]  ts_word_q;

  // hysteresis rule, inside the window the old state holds
  always_comb begin
    for (int i = 0; i < CH; i++) begin
      if ($signed(samples.ch[i]) > $signed(thr_q[i].high))
        next_high[i] = 1'b1;
      else if ($signed(samples.ch[i]) < $signed(thr_q[i].low))
        next_high[i] = 1'b0;
      else
        next_high[i] = is_high[i];
    end
  end

  // kept sample this cycle, the timer bumps the index on the same edge
  assign data_inc = {CH{capture_en & sample_valid}} & next_high;

  always_ff @(posedge clk) begin
    if (reset)
      thr_q <= '0;
    else if (thr_load)
      thr_q <= thr_cfg;
  end

  always_ff @(posedge clk) begin
    if (reset || capture_clear) begin
      is_high   <= '0;
      data_en_q <= '0;
      ts_en_q   <= '0;
    end else begin
      if (sample_valid)
        is_high <= next_high;
      data_en_q <= data_inc;
      ts_en_q   <= data_inc & ~is_high;  // low to high step only
    end
  end

  // record payload, captured with the sample
  always_ff @(posedge clk) begin
    for (int i = 0; i < CH; i++) begin
      if (data_inc[i]) begin
        data_word_q[i].data.channel     <= `SSB_CHAN_W'(i);
        data_word_q[i].data.reserved    <= '0;
        data_word_q[i].data.sample      <= samples.ch[i];
        ts_word_q[i].ts.sample_index    <= sample_index[i];  // index of this very record
        ts_word_q[i].ts.clock           <= sample_clock;     // clock of the crossing sample
      end
    end
  end

  // writes still in flight when capture ends are dropped here
  always_comb begin
    for (int i = 0; i < CH; i++) begin
      data_wr[i].en   = data_en_q[i] & capture_en;
      data_wr[i].word = data_word_q[i];
      ts_wr[i].en     = ts_en_q[i] & capture_en;
      ts_wr[i].word   = ts_word_q[i];
    end
  end

  // nothing is written outside a capture
  a_wr_in_capture: assert property (@(posedge clk) disable iff (reset)
    (|{data_wr[0].en, data_wr[CH-1].en, ts_wr[0].en, ts_wr[CH-1].en}) |-> capture_en);

endmodule

`default_nettype wire

/* verilog/sample_clock_counter.sv */
//--------------------
// sample clock and per-channel stored-sample index counters
//--------------------
`timescale 1ns/1ns
`default_nettype none

`include "ssb_defines.svh"

module sample_clock_counter (
  input  wire                                         clk,
  input  wire                                         reset,
  input  wire                                         capture_clear,
  input  wire                                         sample_valid,
  input  wire [`SSB_CHANNELS-1:0]                     data_inc,
  output logic [`SSB_CLOCK_W-1:0]                     sample_clock,
  output logic [`SSB_CHANNELS-1:0][`SSB_INDEX_W-1:0]  sample_index
);

  // sample_clock holds the count of sample cycles before the current one,
  // so the first sample after capture_clear sees 0
  always_ff @(posedge clk) begin
    if (reset || capture_clear) begin
      sample_clock <= '0;
    end else if (sample_valid) begin
      sample_clock <= sample_clock + 1'b1;  // wraps on long captures
    end
  end

  // one index per channel, counts data records handed to the store
  always_ff @(posedge clk) begin
    if (reset || capture_clear) begin
      sample_index <= '0;
    end else begin
      for (int i = 0; i < `SSB_CHANNELS; i++) begin
        if (data_inc[i])
          sample_index[i] <= sample_index[i] + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/sample_store.sv */
//--------------------
// banked record store, one bank and write port per channel,
// streamed out bank by bank after rd_start
//--------------------
`timescale 1ns/1ns
`default_nettype none

`include "ssb_defines.svh"

module sample_store import ssb_pkg::*; #(
  parameter int DEPTH = 64  // total entries over all banks
) (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 capture_clear,
  input  wire store_wr_t [`SSB_CHANNELS-1:0]  wr,
  input  wire                                 rd_start,
  output out_word_t                           rd_word,
  output logic                                rd_valid,
  input  wire                                 rd_ready,
  output logic                                rd_last,
  output logic                                full,
  output logic                                empty
);

  localparam int CH         = `SSB_CHANNELS;
  localparam int BANK_DEPTH = DEPTH / CH;
  localparam int AW         = $clog2(BANK_DEPTH);
  localparam int PW         = $clog2(BANK_DEPTH + 1);  // pointer reaches BANK_DEPTH
  localparam int BW         = (CH > 1) ? $clog2(CH) : 1;

  out_word_t              mem [CH][BANK_DEPTH];
  logic [CH-1:0][PW-1:0]  wr_ptr;     // entries written per bank
  logic [CH-1:0]          wr_en;
  logic [CH-1:0]          bank_full;
  logic [CH-1:0]          bank_filling;  // last free entry being written now
  logic [CH-1:0]          bank_used;

  logic                   active;     // readout walking the banks
  logic [BW-1:0]          rd_bank;
  logic [PW-1:0]          rd_addr;
  logic                   at_end;     // rd_addr past the bank's last entry
  logic                   later_used; // some later bank holds data
  logic                   take;       // fetch slot this cycle

  always_comb begin
    for (int i = 0; i < CH; i++) begin
      wr_en[i]        = wr[i].en;
      bank_full[i]    = (wr_ptr[i] == PW'(BANK_DEPTH));
      bank_filling[i] = (wr_ptr[i] == PW'(BANK_DEPTH - 1)) & wr[i].en;
      bank_used[i]    = (wr_ptr[i] != '0);
    end
  end

  // full already covers the write that takes the last entry,
  // so capture ends before another write can arrive
  assign full  = |bank_full | |bank_filling;
  assign empty = ~|bank_used;

  always_ff @(posedge clk) begin
    for (int i = 0; i < CH; i++) begin
      if (wr[i].en)
        mem[i][wr_ptr[i][AW-1:0]] <= wr[i].word;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || capture_clear) begin
      wr_ptr <= '0;
    end else begin
      for (int i = 0; i < CH; i++) begin
        if (wr[i].en)
          wr_ptr[i] <= wr_ptr[i] + 1'b1;
      end
    end
  end

  always_comb begin
    later_used = 1'b0;
    for (int j = 0; j < CH; j++) begin
      if (j > int'(rd_bank) && bank_used[j])
        later_used = 1'b1;
    end
  end

  assign at_end = (rd_addr == wr_ptr[rd_bank]);
  assign take   = active & (~rd_valid | rd_ready);  // output reg free or draining

  always_ff @(posedge clk) begin
    if (reset || capture_clear) begin
      active   <= 1'b0;
      rd_valid <= 1'b0;
      rd_last  <= 1'b0;
      rd_bank  <= '0;
      rd_addr  <= '0;
    end else begin
      if (rd_valid && rd_ready) begin
        rd_valid <= 1'b0;
        rd_last  <= 1'b0;
      end
      if (rd_start) begin
        active  <= ~empty;  // nothing to send, stay quiet
        rd_bank <= '0;
        rd_addr <= '0;
      end else if (take) begin
        if (!at_end) begin
          rd_valid <= 1'b1;
          rd_last  <= (rd_addr == wr_ptr[rd_bank] - 1'b1) && !later_used;
          rd_addr  <= rd_addr + 1'b1;
        end else if (rd_bank == BW'(CH - 1)) begin
          active <= 1'b0;  // walked every bank
        end else begin
          rd_bank <= rd_bank + 1'b1;  // empty banks cost one cycle each
          rd_addr <= '0;
        end
      end
    end
  end

  // output word only moves when the slot is free, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (take && !at_end)
      rd_word <= mem[rd_bank][rd_addr[AW-1:0]];
  end

  a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
    (wr_en & bank_full) == '0);

endmodule

`default_nettype wire

/* verilog/capture_sequencer.sv */
//--------------------
// capture sequencer: idle, capture, timestamp then data readout,
// and the output stream mux
//--------------------
`timescale 1ns/1ns
`default_nettype none

module capture_sequencer import ssb_pkg::*; (
  input  wire             clk,
  input  wire             reset,
  input  wire             start,
  input  wire             stop,
  input  wire             start_aux,
  input  wire             ts_full,
  input  wire             data_full,
  input  wire             ts_empty,
  input  wire             data_empty,
  output logic            capture_clear,
  output logic            capture_en,
  output logic            ts_rd_start,
  output logic            data_rd_start,
  input  wire out_word_t  ts_word,
  input  wire             ts_valid,
  input  wire             ts_last,
  output logic            ts_ready,
  input  wire out_word_t  data_word,
  input  wire             data_valid,
  input  wire             data_last,
  output logic            data_ready,
  output out_word_t       out_word,
  output logic            out_valid,
  output logic            out_last,
  input  wire             out_ready,
  output logic            capture_done
);

  typedef enum logic [1:0] {IDLE, CAPTURE, READ_TS, READ_DATA} state_t;

  state_t state;
  logic   aux_q;        // start_aux one cycle back
  logic   aux_edge;
  logic   end_capture;
  logic   ts_done;      // last timestamp word accepted
  logic   data_done;    // last data word accepted

  assign aux_edge    = start_aux & ~aux_q;
  assign end_capture = stop | ts_full | data_full;
  assign capture_en  = (state == CAPTURE);
  assign ts_done     = ts_valid & ts_ready & ts_last;
  assign data_done   = data_valid & data_ready & data_last;

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= IDLE;
      aux_q         <= 1'b0;
      capture_clear <= 1'b0;
      ts_rd_start   <= 1'b0;
      data_rd_start <= 1'b0;
      capture_done  <= 1'b0;
    end else begin
      aux_q         <= start_aux;
      capture_clear <= 1'b0;  // pulses only
      ts_rd_start   <= 1'b0;
      data_rd_start <= 1'b0;
      case (state)
        IDLE: begin
          if (capture_clear) begin  // clear pulse out, capture next
            state        <= CAPTURE;
            capture_done <= 1'b0;
          end else if (start || aux_edge) begin
            capture_clear <= 1'b1;
          end
        end
        CAPTURE: begin
          if (end_capture) begin
            state        <= READ_TS;
            ts_rd_start  <= 1'b1;
            capture_done <= 1'b1;
          end
        end
        READ_TS: begin
          if (ts_empty || ts_done) begin  // empty phase is skipped
            state         <= READ_DATA;
            data_rd_start <= 1'b1;
          end
        end
        READ_DATA: begin
          if (data_empty || data_done) begin
            state        <= IDLE;
            capture_done <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // output mux, ready goes straight back to the selected store
  always_comb begin
    out_word   = ts_word;
    out_valid  = 1'b0;
    out_last   = 1'b0;
    ts_ready   = 1'b0;
    data_ready = 1'b0;
    case (state)
      READ_TS: begin
        out_valid = ts_valid;  // last held back, data follows
        ts_ready  = out_ready;
      end
      READ_DATA: begin
        out_word   = data_word;
        out_valid  = data_valid;
        out_last   = data_last;
        data_ready = out_ready;
      end
      default: ;
    endcase
  end

  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {IDLE, CAPTURE, READ_TS, READ_DATA});
  a_last_in_data: assert property (@(posedge clk) disable iff (reset)
    out_last |-> state == READ_DATA);

endmodule

`default_nettype wire

/* verilog/sparse_sample_buffer.sv */
//--------------------
// sparse sample buffer top: discriminator, timer, data and
// timestamp stores, sequencer
//--------------------
`timescale 1ns/1ns
`default_nettype none

`include "ssb_defines.svh"

module sparse_sample_buffer import ssb_pkg::*; (
  input  wire               clk,
  input  wire               reset,
  input  wire sample_vec_t  samples,
  input  wire               sample_valid,
  input  wire               thr_load,
  input  wire thresholds_t  thr_cfg,
  input  wire               start,
  input  wire               stop,
  input  wire               start_aux,
  output out_word_t         out_word,
  output logic              out_valid,
  output logic              out_last,
  input  wire               out_ready,
  output logic              capture_done
);

  logic                                         capture_clear;
  logic                                         capture_en;
  store_wr_t [`SSB_CHANNELS-1:0]                data_wr;
  store_wr_t [`SSB_CHANNELS-1:0]                ts_wr;
  logic [`SSB_CHANNELS-1:0]                     data_inc;
  logic [`SSB_CLOCK_W-1:0]                      sample_clock;
  logic [`SSB_CHANNELS-1:0][`SSB_INDEX_W-1:0]   sample_index;
  logic                                         data_full, data_empty, data_rd_start;
  logic                                         ts_full, ts_empty, ts_rd_start;
  out_word_t                                    data_word, ts_word;
  logic                                         data_valid, data_ready, data_last;
  logic                                         ts_valid, ts_ready, ts_last;

  threshold_discriminator threshold_discriminator_inst (
    .clk, .reset, .samples, .sample_valid, .thr_load, .thr_cfg,
    .capture_clear, .capture_en, .sample_index, .sample_clock,
    .data_wr, .ts_wr, .data_inc
  );

  sample_clock_counter sample_clock_counter_inst (
    .clk, .reset, .capture_clear, .sample_valid, .data_inc,
    .sample_clock, .sample_index
  );

  sample_store #(.DEPTH(`SSB_DATA_DEPTH)) data_store (
    .clk, .reset, .capture_clear, .wr(data_wr), .rd_start(data_rd_start),
    .rd_word(data_word), .rd_valid(data_valid), .rd_ready(data_ready),
    .rd_last(data_last), .full(data_full), .empty(data_empty)
  );

  sample_store #(.DEPTH(`SSB_TS_DEPTH)) ts_store (
    .clk, .reset, .capture_clear, .wr(ts_wr), .rd_start(ts_rd_start),
    .rd_word(ts_word), .rd_valid(ts_valid), .rd_ready(ts_ready),
    .rd_last(ts_last), .full(ts_full), .empty(ts_empty)
  );

  capture_sequencer capture_sequencer_inst (
    .clk, .reset, .start, .stop, .start_aux,
    .ts_full, .data_full, .ts_empty, .data_empty,
    .capture_clear, .capture_en, .ts_rd_start, .data_rd_start,
    .ts_word, .ts_valid, .ts_last, .ts_ready,
    .data_word, .data_valid, .data_last, .data_ready,
    .out_word, .out_valid, .out_last, .out_ready, .capture_done
  );

endmodule

`default_nettype wire

/* bench/sparse_sample_buffer_tb.sv */
//--------------------
// testbench for the sparse sample buffer: hysteresis model,
// readout checks, back-pressure, full stop and start_aux
//--------------------
`timescale 1ns/1ns
`default_nettype none

`include "ssb_defines.svh"

module sparse_sample_buffer_tb import ssb_pkg::*; ;

  localparam int CH        = `SSB_CHANNELS;
  localparam int DATA_BANK = `SSB_DATA_DEPTH / `SSB_CHANNELS;
  localparam int TS_BANK   = `SSB_TS_DEPTH / `SSB_CHANNELS;
  localparam int RAND_LEN  = 60;  // sample cycles per random capture
  localparam int AUX_LEN   = 20;
  localparam int FULL_LEN  = 40;  // longer than one data bank
  localparam int CAPTURES  = 5;
  localparam int EXP_MAX   = 1024;
  // samples plus per capture some idle cycles and a half-rate readout of both stores
  localparam int TIMEOUT   = 2 * RAND_LEN + AUX_LEN + FULL_LEN
    + CAPTURES * (20 + 3 * (`SSB_DATA_DEPTH + `SSB_TS_DEPTH)) + 100;
  localparam logic [31:0] SEED = 32'hf0b9_78da;

  logic        clk;
  logic        reset;
  sample_vec_t samples;
  logic        sample_valid;
  logic        thr_load;
  thresholds_t thr_cfg;
  logic        start, stop, start_aux;
  out_word_t   out_word;
  logic        out_valid, out_last, out_ready;
  logic        capture_done;

  thresholds_t            thr;            // windows loaded into the DUT
  logic [CH-1:0]          model_high;     // modeled is_high per channel
  logic [`SSB_CLOCK_W-1:0] model_clock;
  logic                   model_stopped;  // a bank filled, later samples are lost
  logic [31:0]            data_model [CH][$];
  logic [31:0]            ts_model [CH][$];
  logic [31:0]            exp_words [EXP_MAX];  // expected stream over all captures
  logic                   exp_ts [EXP_MAX];
  logic                   exp_last [EXP_MAX];
  int                     exp_n = 0;
  int                     rd_idx;         // words transferred so far
  int                     run_len;        // data words of the current bank so far
  int                     cur_run;
  logic [`SSB_CHAN_W-1:0] run_chan;
  logic                   started = 1'b0;
  int                     errors = 0;
  int                     words_checked;
  int                     end_checks = 0;
  int                     cycle_count = 0;

  sparse_sample_buffer sparse_sample_buffer_inst (
    .clk, .reset, .samples, .sample_valid, .thr_load, .thr_cfg,
    .start, .stop, .start_aux, .out_word, .out_valid, .out_last,
    .out_ready, .capture_done
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT) begin
      $display("timeout: readout never finished within %0d cycles", TIMEOUT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("** Error @ %0t: %s", $time, msg);
  endtask

  task automatic flag_failure(input string msg);
    errors++;
    $display("failure at %0t ns: %s", $time, msg);
  endtask

  // transfer bookkeeping, a word moves when valid and ready meet
  assign cur_run = (out_word.data.channel == run_chan) ? run_len + 1 : 1;

  always @(posedge clk) begin
    if (reset) begin
      rd_idx        <= 0;
      run_len       <= 0;
      run_chan      <= '1;  // no channel yet
      words_checked <= 0;
    end else if (out_valid && out_ready) begin
      rd_idx        <= rd_idx + 1;
      words_checked <= words_checked + 1;
      if (exp_ts[rd_idx] || out_last) begin
        run_len  <= 0;
        run_chan <= '1;
      end else begin
        run_len  <= cur_run;
        run_chan <= out_word.data.channel;
      end
    end
  end

  quiet_until_start: assert property (@(posedge clk) disable iff (reset)
    !started |-> (!out_valid && !out_last && !capture_done))
    else flag_mismatch("output active before any capture");

  word_matches: assert property (@(posedge clk) disable iff (reset)
    (out_valid && out_ready) |-> (rd_idx < exp_n && out_word == exp_words[rd_idx]))
    else flag_mismatch($sformatf("word %0d got %h (ch %0d, index %0d, clock %0d), expected %h",
      $sampled(rd_idx), $sampled(out_word), $sampled(out_word.data.channel),
      $sampled(out_word.ts.sample_index), $sampled(out_word.ts.clock),
      exp_words[$sampled(rd_idx)]));

  last_on_final: assert property (@(posedge clk) disable iff (reset)
    (out_valid && out_ready) |-> (out_last == exp_last[rd_idx]))
    else flag_mismatch($sformatf("out_last %0b on word %0d",
      $sampled(out_last), $sampled(rd_idx)));

  word_held: assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_word)))
    else flag_mismatch("word or valid changed under back-pressure");

  bank_bounded: assert property (@(posedge clk) disable iff (reset)
    (out_valid && out_ready && !exp_ts[rd_idx]) |-> (cur_run <= DATA_BANK))
    else flag_mismatch($sformatf("bank %0d sent %0d data words",
      $sampled(run_chan), $sampled(cur_run)));

  // random value above high, inside the window, or below low
  function automatic sample_t pick_value(input int ch, input int region);
    int hi;
    int lo;
    int v;
    hi = int'(thr[ch].high);
    lo = int'(thr[ch].low);
    case (region)
      0: v = hi + 1 + int'($urandom_range(400));
      1: v = lo + int'($urandom_range(hi - lo));
      default: v = lo - 1 - int'($urandom_range(400));
    endcase
    return sample_t'(v);
  endfunction

  // hysteresis rule applied to one sample cycle
  task automatic model_sample(input sample_vec_t s);
    int          v;
    logic        nh;
    data_rec_t   d;
    tstamp_rec_t t;
    if (model_stopped) return;
    for (int ch = 0; ch < CH; ch++) begin
      v = int'(s.ch[ch]);
      if (v > int'(thr[ch].high)) nh = 1'b1;
      else if (v < int'(thr[ch].low)) nh = 1'b0;
      else nh = model_high[ch];
      if (nh) begin
        if (!model_high[ch]) begin  // rising crossing
          t.sample_index = `SSB_INDEX_W'(data_model[ch].size());
          t.clock        = model_clock;
          ts_model[ch].push_back(t);
        end
        d.channel  = `SSB_CHAN_W'(ch);
        d.reserved = '0;
        d.sample   = s.ch[ch];
        data_model[ch].push_back(d);
      end
      model_high[ch] = nh;
    end
    model_clock++;
    for (int ch = 0; ch < CH; ch++) begin
      if (data_model[ch].size() == DATA_BANK || ts_model[ch].size() == TS_BANK)
        model_stopped = 1'b1;  // capture ends, pipeline writes dropped
    end
  endtask

  function automatic logic near_full();
    logic f;
    f = 1'b0;
    for (int ch = 0; ch < CH; ch++) begin
      if (data_model[ch].size() >= DATA_BANK - 4 || ts_model[ch].size() >= TS_BANK - 2)
        f = 1'b1;
    end
    return f;
  endfunction

  task automatic drive_sample(input sample_vec_t s, input logic valid);
    samples      = s;
    sample_valid = valid;
    if (valid) model_sample(s);
    @(negedge clk);
  endtask

  task automatic start_capture(input logic use_aux);
    if (use_aux) start_aux = 1'b1;  // stays high until released
    else start = 1'b1;
    started = 1'b1;
    @(negedge clk);
    start = 1'b0;
    @(negedge clk);  // clear has gone out, capture_en from here
    model_high    = '0;
    model_clock   = '0;
    model_stopped = 1'b0;
    for (int ch = 0; ch < CH; ch++) begin
      data_model[ch].delete();
      ts_model[ch].delete();
    end
  endtask

  task automatic finish_capture();
    sample_valid = 1'b0;
    repeat (2) @(negedge clk);  // let the write pipeline drain
    stop = 1'b1;
    @(negedge clk);
    stop = 1'b0;
  endtask

  // readout order: timestamp banks in channel order, then data banks
  task automatic build_expected();
    int first;
    first = exp_n;
    for (int ch = 0; ch < CH; ch++) begin
      for (int k = 0; k < ts_model[ch].size(); k++) begin
        exp_words[exp_n] = ts_model[ch][k];
        exp_ts[exp_n]    = 1'b1;
        exp_last[exp_n]  = 1'b0;
        exp_n++;
      end
    end
    for (int ch = 0; ch < CH; ch++) begin
      for (int k = 0; k < data_model[ch].size(); k++) begin
        exp_words[exp_n] = data_model[ch][k];
        exp_ts[exp_n]    = 1'b0;
        exp_last[exp_n]  = 1'b0;
        exp_n++;
      end
    end
    if (exp_n > first) exp_last[exp_n-1] = 1'b1;
  endtask

  task automatic read_out(input logic random_ready, input logic poke_start);
    int n;
    build_expected();
    n = 0;
    while (capture_done) begin
      out_ready = random_ready ? ($urandom_range(1) != 0) : 1'b1;
      start     = poke_start && (n == 3);  // ignored outside IDLE
      n++;
      @(negedge clk);
    end
    out_ready = 1'b0;
    start     = 1'b0;
    end_checks++;
    assert (rd_idx == exp_n)
      else flag_failure($sformatf("readout ended after %0d of %0d words", rd_idx, exp_n));
  endtask

  task automatic random_capture(input int len, input logic use_aux);
    sample_vec_t vec;
    start_capture(use_aux);
    for (int n = 0; n < len && !near_full(); n++) begin
      for (int ch = 0; ch < CH; ch++)
        vec.ch[ch] = pick_value(ch, int'($urandom_range(2)));
      drive_sample(vec, $urandom_range(3) != 0);  // gaps in sample_valid
    end
    finish_capture();
  endtask

  initial begin
    sample_vec_t vec;
    void'($urandom(SEED));
    reset        = 1'b1;
    samples      = '0;
    sample_valid = 1'b0;
    thr_load     = 1'b0;
    thr_cfg      = '0;
    start        = 1'b0;
    stop         = 1'b0;
    start_aux    = 1'b0;
    out_ready    = 1'b0;
    thr[0].high  = 16'sd1000;
    thr[0].low   = -16'sd1000;
    thr[1].high  = 16'sd300;
    thr[1].low   = 16'sd100;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    thr_cfg  = thr;
    thr_load = 1'b1;
    @(negedge clk);
    thr_load = 1'b0;
    repeat (5) @(negedge clk);  // outputs must stay quiet here

    // hysteresis and timestamps with a free-running sink
    random_capture(RAND_LEN, 1'b0);
    read_out(1'b0, 1'b0);

    // same again under random back-pressure
    random_capture(RAND_LEN, 1'b0);
    read_out(1'b1, 1'b0);

    // channel 0 held above high until its data bank fills
    start_capture(1'b0);
    vec.ch[0] = thr[0].high + 16'sd50;
    vec.ch[1] = thr[1].low - 16'sd20;
    repeat (FULL_LEN) drive_sample(vec, 1'b1);
    sample_valid = 1'b0;
    @(negedge clk);
    end_checks++;
    assert (capture_done)
      else flag_failure("capture_done did not rise when a data bank filled");
    read_out(1'b1, 1'b0);

    // start_aux held high, start strobe poked during readout
    random_capture(AUX_LEN, 1'b1);
    read_out(1'b1, 1'b1);
    repeat (6) @(negedge clk);
    stop = 1'b1;  // would end a second capture if one had begun
    @(negedge clk);
    stop = 1'b0;
    repeat (3) @(negedge clk);
    end_checks++;
    assert (!capture_done && !out_valid)
      else flag_failure("held start_aux started a second capture");
    start_aux = 1'b0;

    // empty capture sends nothing and returns to idle
    start_capture(1'b0);
    finish_capture();
    read_out(1'b1, 1'b0);
    repeat (4) @(negedge clk);

    $display("words checked: %0d, other checks: %0d, errors: %0d",
      words_checked, end_checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/ssb_pkg.sv
verilog/threshold_discriminator.sv
verilog/sample_clock_counter.sv
verilog/sample_store.sv
verilog/capture_sequencer.sv
verilog/sparse_sample_buffer.sv
bench/sparse_sample_buffer_tb.sv

/* Makefile */
# Verilator build and run for the sparse sample buffer

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = sparse_sample_buffer_tb
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# pass only when the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
